// File: source/motor_io_macros.svh
/*
 * Channel counts and widths for the motor interface peripheral.
 * Duty width also sets the PWM period, 2**MOTOR_PWM_W clocks.
 * The register map assumes four channels of each kind.
 */

`ifndef MOTOR_IO_MACROS_SVH
`define MOTOR_IO_MACROS_SVH

`define MOTOR_NUM_ENC 4   // quadrature encoder channels
`define MOTOR_NUM_PWM 4   // pwm output channels
`define MOTOR_COUNT_W 32  // encoder count, wraps mod 2**32
`define MOTOR_PWM_W   11  // duty and period counter width
`define MOTOR_ADDR_W  8   // apb byte address
`define MOTOR_DATA_W  32  // apb data bus

`endif

// File: source/motor_io_pkg.sv
/*
 * Shared types for the motor interface peripheral.
 * The register map is byte addressed with one 32-bit word per register.
 * Encoder pins are given as {a, b}. a leading b counts up.
 */

`default_nettype none

`include "motor_io_macros.svh"

package motor_io_pkg;

	// apb master to slave
	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [`MOTOR_ADDR_W-1:0] paddr;
		logic [`MOTOR_DATA_W-1:0] pwdata;
	} apb_req_t;

	// slave response, no wait states
	typedef struct packed {
		logic [`MOTOR_DATA_W-1:0] prdata;
		logic                     pready;
		logic                     pslverr;
	} apb_rsp_t;

	// register byte addresses
	typedef enum logic [`MOTOR_ADDR_W-1:0] {
		count_0     = 8'h00, // counts read only
		count_1     = 8'h04,
		count_2     = 8'h08,
		count_3     = 8'h0C,
		duty_0      = 8'h10, // low 11 bits used
		duty_1      = 8'h14,
		duty_2      = 8'h18,
		duty_3      = 8'h1C,
		count_clear = 8'h20  // write only, bit per channel
	} reg_addr_e;

	// one decoded encoder transition
	typedef enum logic [1:0] {step_none, step_up, step_down, step_invalid} quad_step_e;

	typedef struct packed {
		logic a;
		logic b;
	} quad_pins_t;

	typedef logic [`MOTOR_NUM_ENC-1:0][`MOTOR_COUNT_W-1:0] enc_counts_t;
	typedef logic [`MOTOR_NUM_PWM-1:0][`MOTOR_PWM_W-1:0]   pwm_duties_t;

endpackage

`default_nettype wire

// File: source/apb_reg_file.sv
/*
 * APB slave for the motor interface with zero wait states.
 * pready is high in every access cycle and the block never stalls.
 * Addresses decode on the full byte address. Nothing aliases.
 * Errored accesses (unmapped, count write) change no state.
 * count_clear reads as zero and its write makes a one clock pulse.
 */

`default_nettype none

`include "motor_io_macros.svh"

module apb_reg_file (
	input  logic                      clk_50,
	input  logic                      reset,
	input  motor_io_pkg::apb_req_t    apb_req,
	output motor_io_pkg::apb_rsp_t    apb_rsp,
	input  motor_io_pkg::enc_counts_t enc_counts,
	output motor_io_pkg::pwm_duties_t pwm_duties,
	output logic [`MOTOR_NUM_ENC-1:0] count_clear
);

	import motor_io_pkg::*;

	// ===================================================================
	// decode
	// ===================================================================

	logic                     access;   // second phase of a transfer
	logic                     addr_err; // unmapped or illegal direction
	logic                     wr_en;    // legal write this cycle
	logic [1:0]               reg_idx;  // word within a bank of four
	logic [`MOTOR_DATA_W-1:0] rd_data;

	assign access  = apb_req.psel & apb_req.penable;
	assign reg_idx = apb_req.paddr[3:2];
	assign wr_en   = access & apb_req.pwrite & ~addr_err;

	always_comb begin
		rd_data  = '0;
		addr_err = 1'b0;
		case (apb_req.paddr)
			count_0, count_1, count_2, count_3: begin
				rd_data  = enc_counts[reg_idx]; // live count
				addr_err = apb_req.pwrite;      // counts are read only
			end
			duty_0, duty_1, duty_2, duty_3: begin
				// upper bits read back as zero
				rd_data = {{(`MOTOR_DATA_W - `MOTOR_PWM_W){1'b0}}, pwm_duties[reg_idx]};
			end
			motor_io_pkg::count_clear: begin
				rd_data = '0; // write only
			end
			default: begin
				addr_err = 1'b1;
			end
		endcase
	end

	// ===================================================================
	// response
	// ===================================================================

	// all response fields stay quiet outside access cycles
	always_comb begin
		apb_rsp.pready  = access;
		apb_rsp.pslverr = access & addr_err;
		if (access && !apb_req.pwrite && !addr_err)
			apb_rsp.prdata = rd_data;
		else
			apb_rsp.prdata = '0;
	end

	// ===================================================================
	// duty registers and clear pulse
	// ===================================================================

	always_ff @(posedge clk_50) begin
		if (reset) begin
			pwm_duties  <= '0;
			count_clear <= '0;
		end else begin
			count_clear <= '0; // pulse lasts a single clock
			if (wr_en) begin
				case (apb_req.paddr)
					duty_0, duty_1, duty_2, duty_3: begin
						// pwm_bank picks this up at its next wrap
						pwm_duties[reg_idx] <= apb_req.pwdata[`MOTOR_PWM_W-1:0];
					end
					motor_io_pkg::count_clear: begin
						count_clear <= apb_req.pwdata[`MOTOR_NUM_ENC-1:0]; // mask
					end
					default: begin
						// nothing else is writable
					end
				endcase
			end
		end
	end

	// the decoders see the pulse in the clock after the access cycle
	// and zero their counts at the edge that ends it

endmodule

`default_nettype wire

// File: source/quad_decoder.sv
/*
 * One quadrature encoder channel with a 32-bit up/down count.
 * Pins are asynchronous and go through two flops. Count lags pins by 3 clocks.
 * Each pin level must be held at least one clock, or steps are missed.
 * A step arriving in the same clock as clear is dropped.
 */

`default_nettype none

`include "motor_io_macros.svh"

module quad_decoder (
	input  logic                      clk_50,
	input  logic                      reset,
	input  motor_io_pkg::quad_pins_t  pins,
	input  logic                      clear,
	output logic [`MOTOR_COUNT_W-1:0] count
);

	import motor_io_pkg::*;

	quad_pins_t sync_0; // first stage, may go metastable
	quad_pins_t sync_1; // safe to use
	quad_pins_t prev;   // last settled pair
	quad_pins_t delta;  // bits that moved
	quad_step_e step;

	// ===================================================================
	// synchronizer and history
	// ===================================================================

	always_ff @(posedge clk_50) begin
		if (reset) begin
			sync_0 <= '0;
			sync_1 <= '0;
			prev   <= '0;
		end else begin
			sync_0 <= pins;
			sync_1 <= sync_0;
			prev   <= sync_1;
		end
	end

	// ===================================================================
	// step decode
	// ===================================================================

	assign delta = sync_1 ^ prev;

	// gray sequence 00 10 11 01 counts up
	// old a xor new b is low going forward, high going back
	always_comb begin
		case (delta)
			2'b00:   step = step_none;
			2'b11:   step = step_invalid; // skipped a state
			default: step = (prev.a ^ sync_1.b) ? step_down : step_up;
		endcase
	end

	always_ff @(posedge clk_50) begin
		if (reset) begin
			count <= '0;
		end else if (clear) begin
			count <= '0; // wins over a step
		end else begin
			case (step)
				step_up:   count <= count + 1'b1; // wraps mod 2**32
				step_down: count <= count - 1'b1;
				default:   count <= count;        // none or invalid
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/pwm_bank.sv
/*
 * PWM outputs sharing one free-running 11-bit period counter.
 * Period is 2048 clocks. Duty D gives D high clocks, so 2047 is the max.
 * New duties take effect only at the wrap from 2047 to 0.
 * Outputs are registered one clock behind the counter.
 */

`default_nettype none

`include "motor_io_macros.svh"

module pwm_bank (
	input  logic                      clk_50,
	input  logic                      reset,
	input  motor_io_pkg::pwm_duties_t pwm_duties,
	output logic [`MOTOR_NUM_PWM-1:0] pwm_out
);

	import motor_io_pkg::*;

	logic [`MOTOR_PWM_W-1:0] period_cnt; // shared by all channels
	logic                    wrap;       // last clock of the period
	pwm_duties_t             active;     // duties for the running period

	assign wrap = (period_cnt == '1);

	// ===================================================================
	// period counter and duty latch
	// ===================================================================

	always_ff @(posedge clk_50) begin
		if (reset) begin
			period_cnt <= '0;
			active     <= '0;
		end else begin
			period_cnt <= period_cnt + 1'b1; // rolls over naturally
			if (wrap)
				active <= pwm_duties; // glitch free duty change
		end
	end

	// ===================================================================
	// comparators
	// ===================================================================

	// active is already updated when the counter reads zero,
	// so each period sees exactly one duty value
	always_ff @(posedge clk_50) begin
		if (reset) begin
			pwm_out <= '0;
		end else begin
			for (int i = 0; i < `MOTOR_NUM_PWM; i++) begin
				pwm_out[i] <= (period_cnt < active[i]); // high for counts 0..D-1
			end
		end
	end

endmodule

`default_nettype wire

// File: source/motor_io_top.sv
/*
 * Motor interface peripheral. Four encoder counters and four PWM outputs
 * sit behind an APB register block with zero wait states.
 * enc_pins are asynchronous and synchronized in each decoder.
 * Single clock domain and synchronous active high reset.
 */

`default_nettype none

`include "motor_io_macros.svh"

module motor_io_top (
	input  logic                                                clk_50,
	input  logic                                                reset,
	input  motor_io_pkg::apb_req_t                              apb_req,
	output motor_io_pkg::apb_rsp_t                              apb_rsp,
	input  motor_io_pkg::quad_pins_t [`MOTOR_NUM_ENC-1:0]       enc_pins,
	output logic [`MOTOR_NUM_PWM-1:0]                           pwm_out
);

	import motor_io_pkg::*;

	enc_counts_t               enc_counts;  // decoders back to registers
	pwm_duties_t               pwm_duties;  // registers to pwm bank
	logic [`MOTOR_NUM_ENC-1:0] count_clear; // per channel clear pulse

	// ===================================================================
	// register block
	// ===================================================================

	apb_reg_file apb_reg_file_inst (
		.clk_50      (clk_50),
		.reset       (reset),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.enc_counts  (enc_counts),
		.pwm_duties  (pwm_duties),
		.count_clear (count_clear)
	);

	// one decoder per channel, clear fanned out by bit
	for (genvar i = 0; i < `MOTOR_NUM_ENC; i++) begin : gen_enc
		quad_decoder quad_decoder_inst (
			.clk_50 (clk_50),
			.reset  (reset),
			.pins   (enc_pins[i]),
			.clear  (count_clear[i]),
			.count  (enc_counts[i])
		);
	end

	pwm_bank pwm_bank_inst (
		.clk_50     (clk_50),
		.reset      (reset),
		.pwm_duties (pwm_duties),
		.pwm_out    (pwm_out)
	);

endmodule

`default_nettype wire

// File: verification/motor_io_props.sv
/*
 * APB response and PWM reset checks for motor_io_top, attached by bind.
 * Assumes zero wait state APB, so pready is required in every access cycle.
 * Reports through assertion failures only.
 */

`default_nettype none

`include "motor_io_macros.svh"

module motor_io_props (
	input logic                      clk_50,
	input logic                      reset,
	input motor_io_pkg::apb_req_t    apb_req,
	input motor_io_pkg::apb_rsp_t    apb_rsp,
	input logic [`MOTOR_NUM_PWM-1:0] pwm_out
);

	timeunit 1ns;
	timeprecision 1ps;

	import motor_io_pkg::*;

	logic access; // second phase of a transfer

	assign access = apb_req.psel & apb_req.penable;

	// ===================================================================
	// apb response
	// ===================================================================

	pready_in_access: assert property (@(posedge clk_50) disable iff (reset)
		access |-> apb_rsp.pready)
		else $error("pready low in an APB access cycle");

	pslverr_quiet: assert property (@(posedge clk_50) disable iff (reset)
		!access |-> !apb_rsp.pslverr)
		else $error("pslverr high outside an APB access cycle");

	// registered outputs, reset shows one clock later
	pwm_low_in_reset: assert property (@(posedge clk_50)
		reset |=> (pwm_out == '0))
		else $error("pwm_out not low during reset");

endmodule

bind motor_io_top motor_io_props motor_io_props_inst (
	.clk_50  (clk_50),
	.reset   (reset),
	.apb_req (apb_req),
	.apb_rsp (apb_rsp),
	.pwm_out (pwm_out)
);

`default_nettype wire

// File: verification/motor_io_tb.sv
/*
 * Testbench for motor_io_top. Covers APB register access, encoder counting,
 * counter clear and PWM duty.
 * Random values come from a fixed-seed LFSR, so every run is the same.
 * Encoder levels are held 2 or 3 clocks, slower than the decoder needs.
 * Stops at the first mismatch.
 */

`default_nettype none

`include "motor_io_macros.svh"

module motor_io_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import motor_io_pkg::*;

	localparam int NUM_STEPS       = 40; // step slots, all channels move together
	localparam int DUTY_W          = `MOTOR_PWM_W;
	localparam int PERIOD          = 1 << `MOTOR_PWM_W;
	localparam int WATCHDOG_CLOCKS = NUM_STEPS * 8 + 6 * PERIOD + 1000;

	logic                            clk_50;
	logic                            reset;
	apb_req_t                        apb_req;
	apb_rsp_t                        apb_rsp;
	quad_pins_t [`MOTOR_NUM_ENC-1:0] enc_pins;
	logic [`MOTOR_NUM_PWM-1:0]       pwm_out;

	logic [31:0] lfsr_state = 32'ha25f;
	logic [31:0] model_count [`MOTOR_NUM_ENC]; // expected counts
	logic [1:0]  pos [`MOTOR_NUM_ENC];         // place in the gray sequence
	int          high_clocks [`MOTOR_NUM_PWM];
	int          error_count = 0;

	// results waiting for the compare process
	string       what_q [$];
	logic [31:0] act_q [$];
	logic [31:0] exp_q [$];

	motor_io_top motor_io_top_inst (
		.clk_50   (clk_50),
		.reset    (reset),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.enc_pins (enc_pins),
		.pwm_out  (pwm_out)
	);

	initial begin : clock_gen
		clk_50 = 1'b0;
		forever #5 clk_50 = ~clk_50; // 100 MHz in sim, name kept from the board
	end

	// ===================================================================
	// reference models
	// ===================================================================

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val        = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] next_count(input logic [31:0] count, input quad_step_e step);
		case (step)
			step_up:   return count + 32'd1; // mod 2**32
			step_down: return count - 32'd1;
			default:   return count;         // none and invalid hold
		endcase
	endfunction

	// high clocks per period equal the duty
	function automatic int expected_high(input logic [`MOTOR_PWM_W-1:0] duty);
		return int'(duty);
	endfunction

	// forward order of {a, b}: 00 10 11 01
	function automatic quad_pins_t gray_pins(input logic [1:0] p);
		case (p)
			2'd0:    return 2'b00;
			2'd1:    return 2'b10;
			2'd2:    return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	function automatic logic [7:0] count_addr(input int ch);
		return 8'(count_0) + 8'(4 * ch);
	endfunction

	function automatic logic [7:0] duty_addr(input int ch);
		return 8'(duty_0) + 8'(4 * ch);
	endfunction

	// ===================================================================
	// checking
	// ===================================================================

	task automatic check_equal(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("tests failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic post_result(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		what_q.push_back(what);
		act_q.push_back(actual);
		exp_q.push_back(expected);
	endtask

	initial begin : compare
		forever begin
			wait (act_q.size() != 0);
			check_equal(what_q.pop_front(), act_q.pop_front(), exp_q.pop_front());
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CLOCKS * 10);
		$display("timeout: the run did not finish within %0d clocks", WATCHDOG_CLOCKS);
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	// ===================================================================
	// drivers, all entered 1 ns after a rising edge
	// ===================================================================

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk_50);
		#1;
	endtask

	task automatic apb_transfer(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		waits           = 0;
		apb_req.psel    = 1'b1; // setup
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk_50);
		#1;
		apb_req.penable = 1'b1; // access
		@(negedge clk_50);      // response settled mid cycle
		while (apb_rsp.pready !== 1'b1) begin
			if (waits == 16) begin
				$display("APB transfer to address %h never got pready", addr);
				$display("tests failed");
				$fatal(1, "APB handshake lost");
			end else begin
				waits++;
				@(negedge clk_50);
			end
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk_50); // write lands here
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic check_all_counts(input string tag);
		logic [31:0] rdata;
		logic        err;
		for (int ch = 0; ch < `MOTOR_NUM_ENC; ch++) begin
			apb_read(count_addr(ch), rdata, err);
			post_result($sformatf("count_%0d %s", ch, tag), rdata, model_count[ch]);
			post_result($sformatf("pslverr on count_%0d read", ch), err, 32'd0);
		end
	endtask

	// one full period, sampled at falling edges
	task automatic measure_high();
		for (int i = 0; i < `MOTOR_NUM_PWM; i++)
			high_clocks[i] = 0;
		repeat (PERIOD) begin
			@(negedge clk_50);
			for (int i = 0; i < `MOTOR_NUM_PWM; i++)
				if (pwm_out[i] === 1'b1)
					high_clocks[i]++;
		end
		@(posedge clk_50);
		#1;
	endtask

	// ===================================================================
	// stimulus
	// ===================================================================

	initial begin : stimulus
		logic [31:0]             rdata;
		logic [31:0]             wdata;
		logic                    err;
		logic [3:0]              mask;
		logic [1:0]              r;
		logic [`MOTOR_PWM_W-1:0] duty [`MOTOR_NUM_PWM];
		quad_step_e              step;
		int                      hold;

		reset    = 1'b1;
		apb_req  = '0;
		enc_pins = '0;
		for (int ch = 0; ch < `MOTOR_NUM_ENC; ch++) begin
			model_count[ch] = '0;
			pos[ch]         = '0;
		end
		repeat (2) @(posedge clk_50);
		#1;
		reset = 1'b0;

		// reset state: registers zero, pwm quiet
		for (int ch = 0; ch < `MOTOR_NUM_ENC; ch++) begin
			apb_read(duty_addr(ch), rdata, err);
			post_result($sformatf("duty_%0d after reset", ch), rdata, 32'd0);
			post_result("pslverr on duty read", err, 32'd0);
		end
		check_all_counts("after reset");
		measure_high();
		for (int ch = 0; ch < `MOTOR_NUM_PWM; ch++)
			post_result($sformatf("pwm_%0d high clocks after reset", ch), high_clocks[ch],
				expected_high('0));

		// duty readback and error responses
		for (int ch = 0; ch < `MOTOR_NUM_PWM; ch++) begin
			wdata = rand_bits(32);
			apb_write(duty_addr(ch), wdata, err);
			post_result("pslverr on duty write", err, 32'd0);
			apb_read(duty_addr(ch), rdata, err);
			post_result($sformatf("duty_%0d readback", ch), rdata,
				wdata & ((32'd1 << `MOTOR_PWM_W) - 32'd1));
		end
		apb_read(8'h24, rdata, err); // past the map
		post_result("data of unmapped read", rdata, 32'd0);
		post_result("pslverr of unmapped read", err, 32'd1);
		apb_read(8'h13, rdata, err); // unaligned, full decode
		post_result("pslverr of unaligned read", err, 32'd1);
		apb_read(8'(count_clear), rdata, err);
		post_result("count_clear readback", rdata, 32'd0);
		post_result("pslverr of count_clear read", err, 32'd0);
		apb_write(count_addr(1), rand_bits(32) | 32'd1, err);
		post_result("pslverr of count_1 write", err, 32'd1);
		check_all_counts("after rejected write");

		// legal steps, first one down on every channel
		for (int s = 0; s < NUM_STEPS; s++) begin
			for (int ch = 0; ch < `MOTOR_NUM_ENC; ch++) begin
				r = 2'(rand_bits(2));
				if (s == 0)
					step = step_down; // wraps to all ones
				else if (!r[0])
					step = step_none;
				else if (r[1])
					step = step_up;
				else
					step = step_down;
				if (step == step_up)
					pos[ch] = pos[ch] + 2'd1;
				else if (step == step_down)
					pos[ch] = pos[ch] - 2'd1;
				enc_pins[ch]    = gray_pins(pos[ch]);
				model_count[ch] = next_count(model_count[ch], step);
			end
			hold = 2 + rand_bits(1);
			wait_clocks(hold);
		end
		wait_clocks(4); // drain the 3 clock pipeline
		check_all_counts("after steps");

		// both pins at once
		repeat (3) begin
			for (int ch = 0; ch < `MOTOR_NUM_ENC; ch++) begin
				pos[ch]         = pos[ch] + 2'd2;
				enc_pins[ch]    = gray_pins(pos[ch]);
				model_count[ch] = next_count(model_count[ch], step_invalid);
			end
			wait_clocks(3);
		end
		wait_clocks(4);
		check_all_counts("after invalid steps");

		// masked clear
		mask = 4'(rand_bits(4));
		if (mask == 4'h0)
			mask = 4'h5;
		apb_write(8'(count_clear), {28'd0, mask}, err);
		post_result("pslverr on count_clear write", err, 32'd0);
		for (int ch = 0; ch < `MOTOR_NUM_ENC; ch++)
			if (mask[ch])
				model_count[ch] = '0;
		check_all_counts("after clear");

		// pwm high time, both extremes included
		duty[0] = '0;
		duty[1] = '1; // 2047
		duty[2] = DUTY_W'(rand_bits(`MOTOR_PWM_W));
		duty[3] = DUTY_W'(rand_bits(`MOTOR_PWM_W));
		for (int ch = 0; ch < `MOTOR_NUM_PWM; ch++) begin
			apb_write(duty_addr(ch), 32'(duty[ch]), err);
			post_result("pslverr on duty write", err, 32'd0);
		end
		wait_clocks(PERIOD + 4); // past the next wrap
		measure_high();
		for (int ch = 0; ch < `MOTOR_NUM_PWM; ch++)
			post_result($sformatf("pwm_%0d high clocks", ch), high_clocks[ch],
				expected_high(duty[ch]));

		wait (act_q.size() == 0);
		#1;
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: motor_io.f
+incdir+source
source/motor_io_pkg.sv
source/apb_reg_file.sv
source/quad_decoder.sv
source/pwm_bank.sv
source/motor_io_top.sv
verification/motor_io_props.sv
verification/motor_io_tb.sv

// File: Bender.yml
package:
  name: motor_io

sources:
  - include_dirs:
      - source
    files:
      - source/motor_io_pkg.sv
      - source/apb_reg_file.sv
      - source/quad_decoder.sv
      - source/pwm_bank.sv
      - source/motor_io_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/motor_io_props.sv
      - verification/motor_io_tb.sv
